//--- sim.f
mm_geom_pkg.sv
mm_ctrl_pkg.sv
shared_mem.sv
mem_arbiter.sv
operand_buffer.sv
matmul_engine.sv
dma_engine.sv
mm_accel_top.sv
tb_mm_accel.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f sim.f --top-module tb_mm_accel -o tb_mm_accel
./obj_dir/tb_mm_accel > sim.log 2>&1
cat sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

//--- tb_mm_accel.sv
// random-stimulus testbench for the matrix-multiply accelerator
// drives the host port and start on falling edges, checks memory and C against a model
`default_nettype none

module tb_mm_accel;
    import mm_geom_pkg::*;
    import mm_ctrl_pkg::*;

    // per-wait limits in clock cycles
    localparam int ACK_TIMEOUT  = 50;
    localparam int DONE_TIMEOUT = 2000;
    // longer than a whole job, so a restarted job would show up
    localparam int QUIET_WINDOW = 300;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      host_req;
    mem_op_e   host_op;
    mem_addr_t host_addr;
    mem_word_t host_wdata;
    logic      host_ack;
    mem_word_t host_rdata;
    mem_addr_t mat_a_addr;
    mem_addr_t mat_b_addr;
    mem_addr_t mat_c_addr;
    logic      start;
    logic      done;

    // mirror of the shared memory
    mem_word_t model_mem [2**MEM_AW];
    // layout of the current job
    mem_addr_t a_base;
    mem_addr_t b_base;
    mem_addr_t c_base;
    // 64-word host scratch area, clear of A, B and C
    mem_addr_t h_base;

    int   err_cnt   = 0;
    int   check_cnt = 0;
    int   test_cnt  = 0;
    int   test_fail = 0;
    int   test_err0 = 0;
    int   done_cnt  = 0;
    logic aborted   = 1'b0;

    mm_accel_top u_mm_accel_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .host_req_i   (host_req),
        .host_op_i    (host_op),
        .host_addr_i  (host_addr),
        .host_wdata_i (host_wdata),
        .host_ack_o   (host_ack),
        .host_rdata_o (host_rdata),
        .mat_a_addr_i (mat_a_addr),
        .mat_b_addr_i (mat_b_addr),
        .mat_c_addr_i (mat_c_addr),
        .start_i      (start),
        .done_o       (done)
    );

    always #20 clk = ~clk;

    // count done pulses mid-cycle
    always @(negedge clk) begin
        if (rst_n && done) begin
            done_cnt <= done_cnt + 1;
        end
    end

    task automatic check_word(input string name, input mem_word_t exp, input mem_word_t act);
        if (!aborted) begin
            check_cnt++;
            if (act !== exp) begin
                err_cnt++;
                $display("Error %s: expected %h, actual %h", name, exp, act);
            end
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (!aborted) begin
            check_cnt++;
            if (act !== exp) begin
                err_cnt++;
                $display("Error %s: expected %b, actual %b", name, exp, act);
            end
        end
    endtask

    // later steps are skipped once a wait has run out
    task automatic abort_run(input string what);
        err_cnt++;
        aborted = 1'b1;
        $display("Timeout: no %s within the allowed cycles, remaining steps skipped", what);
    endtask

    task automatic wait_host_ack(input logic level, input string what);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (host_ack !== level && n < ACK_TIMEOUT);
        if (host_ack !== level) begin
            abort_run(what);
        end
    endtask

    // one full four-phase cycle, entered and left on a falling edge
    task automatic host_access(input mem_op_e op, input mem_addr_t addr,
                               input mem_word_t wdata, output mem_word_t rdata);
        rdata = '0;
        if (!aborted) begin
            host_req   = 1'b1;
            host_op    = op;
            host_addr  = addr;
            host_wdata = wdata;
            wait_host_ack(1'b1, "host ack rise");
            // read data valid while ack is high
            rdata    = host_rdata;
            host_req = 1'b0;
            if (!aborted) begin
                wait_host_ack(1'b0, "host ack fall");
            end
        end
    endtask

    task automatic host_write(input mem_addr_t addr, input mem_word_t data);
        mem_word_t unused;
        host_access(MEM_WRITE, addr, data, unused);
        model_mem[addr] = data;
    endtask

    task automatic host_read(input mem_addr_t addr, output mem_word_t data);
        host_access(MEM_READ, addr, '0, data);
    endtask

    task automatic wait_cycles(input int n);
        if (!aborted) begin
            repeat (n) @(negedge clk);
        end
    endtask

    task automatic wait_done(input int target);
        int n;
        n = 0;
        while (!aborted && done_cnt < target && n < DONE_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!aborted && done_cnt < target) begin
            abort_run("done_o pulse");
        end
    endtask

    // extremes show up about one element in four
    function automatic elem_t rand_elem();
        int    r;
        elem_t e;
        r = int'($urandom % 8);
        case (r)
            0:       e = elem_t'(8'h80);
            1:       e = elem_t'(8'h7f);
            default: e = elem_t'($urandom);
        endcase
        return e;
    endfunction

    function automatic mem_word_t rand_row();
        mem_word_t row;
        for (int k = 0; k < MAT_N; k++) begin
            row[k*ELEM_W +: ELEM_W] = rand_elem();
        end
        return row;
    endfunction

    // C[i][j] as the sum over k of A[i][k] * B[k][j], taken from the model
    function automatic acc_t ref_c(input int i, input int j);
        mem_word_t a_row;
        mem_word_t b_row;
        elem_t     a_e;
        elem_t     b_e;
        int        sum;
        sum   = 0;
        a_row = model_mem[mem_addr_t'(a_base + i)];
        for (int k = 0; k < MAT_N; k++) begin
            b_row = model_mem[mem_addr_t'(b_base + k)];
            a_e   = a_row[k*ELEM_W +: ELEM_W];
            b_e   = b_row[j*ELEM_W +: ELEM_W];
            sum  += int'(a_e) * int'(b_e);
        end
        return acc_t'(sum);
    endfunction

    // four 64-word quarters rotated by a random amount, so bases wrap at 256
    task automatic pick_layout;
        mem_addr_t rot;
        rot    = mem_addr_t'($urandom);
        a_base = rot + mem_addr_t'($urandom % 60);
        b_base = rot + 8'd64 + mem_addr_t'($urandom % 60);
        c_base = rot + 8'd128 + mem_addr_t'($urandom % 48);
        h_base = rot + 8'd192;
    endtask

    task automatic load_operands;
        for (int r = 0; r < MAT_N; r++) begin
            host_write(a_base + mem_addr_t'(r), rand_row());
            host_write(b_base + mem_addr_t'(r), rand_row());
        end
    endtask

    task automatic start_job;
        if (!aborted) begin
            mat_a_addr = a_base;
            mat_b_addr = b_base;
            mat_c_addr = c_base;
            start      = 1'b1;
            @(negedge clk);
            start      = 1'b0;
        end
    endtask

    // model takes the product, then all 16 words are read back
    task automatic check_c(input string name);
        mem_word_t got;
        mem_addr_t addr;
        for (int i = 0; i < MAT_N; i++) begin
            for (int j = 0; j < MAT_N; j++) begin
                addr = c_base + mem_addr_t'(MAT_N*i + j);
                model_mem[addr] = mem_word_t'(ref_c(i, j));
            end
        end
        for (int i = 0; i < MAT_N; i++) begin
            for (int j = 0; j < MAT_N; j++) begin
                addr = c_base + mem_addr_t'(MAT_N*i + j);
                host_read(addr, got);
                check_word($sformatf("%s C[%0d][%0d]", name, i, j), model_mem[addr], got);
            end
        end
    endtask

    task automatic run_job(input string name);
        int target;
        target = done_cnt + 1;
        start_job();
        wait_done(target);
        check_c(name);
    endtask

    task automatic begin_test;
        test_err0 = err_cnt;
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        if (err_cnt == test_err0) begin
            $display("test %-12s passed", name);
        end else begin
            test_fail++;
            $display("test %-12s failed with %0d errors", name, err_cnt - test_err0);
        end
    endtask

    initial begin
        mem_word_t got;
        mem_addr_t addr;
        mem_addr_t addrs [32];
        int        target;

        rst_n      = 1'b0;
        host_req   = 1'b0;
        host_op    = MEM_READ;
        host_addr  = '0;
        host_wdata = '0;
        mat_a_addr = '0;
        mat_b_addr = '0;
        mat_c_addr = '0;
        start      = 1'b0;
        void'($urandom(32'hbb72));

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // outputs quiet out of reset
        begin_test();
        check_flag("reset done_o", 1'b0, done);
        check_flag("reset host_ack_o", 1'b0, host_ack);
        end_test("reset");

        // known contents everywhere, pattern built from the whole address
        begin_test();
        for (int a = 0; a < 2**MEM_AW; a++) begin
            addr = mem_addr_t'(a);
            host_write(addr, {addr, ~addr, addr ^ 8'ha5, 8'h3c});
        end
        for (int n = 0; n < 32; n++) begin
            addrs[n] = mem_addr_t'($urandom);
            host_write(addrs[n], mem_word_t'($urandom));
        end
        for (int n = 0; n < 32; n++) begin
            host_read(addrs[n], got);
            check_word($sformatf("host_rw addr %h", addrs[n]), model_mem[addrs[n]], got);
        end
        end_test("host_rw");

        // one job, then the whole memory so nothing outside C moved
        begin_test();
        pick_layout();
        load_operands();
        run_job("single");
        for (int a = 0; a < 2**MEM_AW; a++) begin
            addr = mem_addr_t'(a);
            host_read(addr, got);
            check_word($sformatf("single mem %h", addr), model_mem[addr], got);
        end
        end_test("single");

        // host traffic in the scratch area while the DMA engine runs
        begin_test();
        pick_layout();
        load_operands();
        target = done_cnt + 1;
        start_job();
        for (int n = 0; n < 24; n++) begin
            addr = h_base + mem_addr_t'($urandom % 64);
            if ($urandom % 2 == 0) begin
                host_write(addr, mem_word_t'($urandom));
            end else begin
                host_read(addr, got);
                check_word($sformatf("contention read %h", addr), model_mem[addr], got);
            end
        end
        wait_done(target);
        check_c("contention");
        end_test("contention");

        // second start mid-run with other bases left on the inputs
        begin_test();
        pick_layout();
        load_operands();
        target = done_cnt + 1;
        start_job();
        wait_cycles(6);
        mat_a_addr = mem_addr_t'($urandom);
        mat_b_addr = mem_addr_t'($urandom);
        mat_c_addr = mem_addr_t'($urandom);
        start      = 1'b1;
        @(negedge clk);
        start      = 1'b0;
        wait_done(target);
        wait_cycles(QUIET_WINDOW);
        check_flag("busy_start extra done_o", 1'b0, done_cnt != target);
        check_c("busy_start");
        end_test("busy_start");

        begin_test();
        for (int r = 0; r < 10; r++) begin
            pick_layout();
            load_operands();
            run_job($sformatf("back_to_back run %0d", r));
        end
        end_test("back_to_back");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_cnt, test_fail, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mm_accel_top.sv
// matrix-multiply accelerator top level
// host port and DMA engine share one memory through the arbiter
`default_nettype none

module mm_accel_top (
    input  wire                         clk,
    input  wire                         rst_n,
    // host memory port
    input  wire                         host_req_i,
    input  wire mm_ctrl_pkg::mem_op_e   host_op_i,
    input  wire mm_geom_pkg::mem_addr_t host_addr_i,
    input  wire mm_geom_pkg::mem_word_t host_wdata_i,
    output logic                        host_ack_o,
    output mm_geom_pkg::mem_word_t      host_rdata_o,
    // job control
    input  wire mm_geom_pkg::mem_addr_t mat_a_addr_i,
    input  wire mm_geom_pkg::mem_addr_t mat_b_addr_i,
    input  wire mm_geom_pkg::mem_addr_t mat_c_addr_i,
    input  wire                         start_i,
    output logic                        done_o
);
    import mm_geom_pkg::*;
    import mm_ctrl_pkg::*;

    // DMA requester
    logic               dma_req;
    mem_op_e            dma_op;
    mem_addr_t          dma_addr;
    mem_word_t          dma_wdata;
    logic               dma_ack;
    mem_word_t          dma_rdata;
    // memory
    logic               mem_en;
    logic               mem_we;
    mem_addr_t          mem_addr;
    mem_word_t          mem_wdata;
    mem_word_t          mem_rdata;
    // operand buffer
    logic               buf_we;
    logic               buf_sel_b;
    logic [ROW_W-1:0]   buf_row;
    mem_word_t          buf_wdata;
    logic [ROW_W-1:0]   a_row;
    logic [ROW_W-1:0]   b_row;
    mem_word_t          a_rdata;
    mem_word_t          b_rdata;
    // MAC engine
    logic               mm_start;
    logic               mm_done;
    logic [C_IDX_W-1:0] c_idx;
    acc_t               c_data;

    dma_engine u_dma_engine (
        .clk          (clk),
        .rst_n        (rst_n),
        .mat_a_addr_i (mat_a_addr_i),
        .mat_b_addr_i (mat_b_addr_i),
        .mat_c_addr_i (mat_c_addr_i),
        .start_i      (start_i),
        .done_o       (done_o),
        .mem_req_o    (dma_req),
        .mem_op_o     (dma_op),
        .mem_addr_o   (dma_addr),
        .mem_wdata_o  (dma_wdata),
        .mem_ack_i    (dma_ack),
        .mem_rdata_i  (dma_rdata),
        .buf_we_o     (buf_we),
        .buf_sel_b_o  (buf_sel_b),
        .buf_row_o    (buf_row),
        .buf_wdata_o  (buf_wdata),
        .mm_start_o   (mm_start),
        .mm_done_i    (mm_done),
        .c_idx_o      (c_idx),
        .c_data_i     (c_data)
    );

    mem_arbiter u_mem_arbiter (
        .clk          (clk),
        .rst_n        (rst_n),
        .host_req_i   (host_req_i),
        .host_op_i    (host_op_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .host_ack_o   (host_ack_o),
        .host_rdata_o (host_rdata_o),
        .dma_req_i    (dma_req),
        .dma_op_i     (dma_op),
        .dma_addr_i   (dma_addr),
        .dma_wdata_i  (dma_wdata),
        .dma_ack_o    (dma_ack),
        .dma_rdata_o  (dma_rdata),
        .mem_en_o     (mem_en),
        .mem_we_o     (mem_we),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .mem_rdata_i  (mem_rdata)
    );

    shared_mem u_shared_mem (
        .clk     (clk),
        .en_i    (mem_en),
        .we_i    (mem_we),
        .addr_i  (mem_addr),
        .wdata_i (mem_wdata),
        .rdata_o (mem_rdata)
    );

    operand_buffer u_operand_buffer (
        .clk       (clk),
        .we_i      (buf_we),
        .sel_b_i   (buf_sel_b),
        .wrow_i    (buf_row),
        .wdata_i   (buf_wdata),
        .a_row_i   (a_row),
        .b_row_i   (b_row),
        .a_rdata_o (a_rdata),
        .b_rdata_o (b_rdata)
    );

    matmul_engine u_matmul_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (mm_start),
        .a_row_o   (a_row),
        .b_row_o   (b_row),
        .a_rdata_i (a_rdata),
        .b_rdata_i (b_rdata),
        .done_o    (mm_done),
        .c_idx_i   (c_idx),
        .c_data_o  (c_data)
    );

endmodule

`default_nettype wire

//--- dma_engine.sv
// DMA engine: fetches A and B rows into the operand buffer, runs the MAC engine,
// then stores the 16 results of C, pulsing done_o after the last write
// each memory transfer is one full four-phase req/ack cycle
`default_nettype none

module dma_engine (
    input  wire                              clk,
    input  wire                              rst_n,
    // configuration
    input  wire mm_geom_pkg::mem_addr_t      mat_a_addr_i,
    input  wire mm_geom_pkg::mem_addr_t      mat_b_addr_i,
    input  wire mm_geom_pkg::mem_addr_t      mat_c_addr_i,
    input  wire                              start_i,
    output logic                             done_o,
    // memory requester port
    output logic                             mem_req_o,
    output mm_ctrl_pkg::mem_op_e             mem_op_o,
    output mm_geom_pkg::mem_addr_t           mem_addr_o,
    output mm_geom_pkg::mem_word_t           mem_wdata_o,
    input  wire                              mem_ack_i,
    input  wire mm_geom_pkg::mem_word_t      mem_rdata_i,
    // operand buffer write port
    output logic                             buf_we_o,
    output logic                             buf_sel_b_o,
    output logic [mm_geom_pkg::ROW_W-1:0]    buf_row_o,
    output mm_geom_pkg::mem_word_t           buf_wdata_o,
    // MAC engine
    output logic                             mm_start_o,
    input  wire                              mm_done_i,
    output logic [mm_geom_pkg::C_IDX_W-1:0]  c_idx_o,
    input  wire mm_geom_pkg::acc_t           c_data_i
);
    import mm_geom_pkg::*;
    import mm_ctrl_pkg::*;

    dma_state_e          state_q;
    logic [ROW_W-1:0]    row_q;
    logic [C_IDX_W-1:0]  c_cnt_q;
    // bases latched at start
    mem_addr_t           a_base_q;
    mem_addr_t           b_base_q;
    mem_addr_t           c_base_q;
    logic                xfer_done;
    logic                can_req;
    logic                rd_state;

    // ack of our own request ends a transfer
    assign xfer_done = mem_req_o && mem_ack_i;
    // previous handshake fully closed
    assign can_req   = !mem_req_o && !mem_ack_i;
    assign rd_state  = (state_q == DMA_RD_A) || (state_q == DMA_RD_B);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= DMA_IDLE;
            mem_req_o  <= 1'b0;
            row_q      <= '0;
            c_cnt_q    <= '0;
            mm_start_o <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            mm_start_o <= 1'b0;
            done_o     <= 1'b0;
            case (state_q)
                DMA_IDLE: begin
                    // start ignored anywhere else
                    if (start_i) begin
                        row_q   <= '0;
                        c_cnt_q <= '0;
                        state_q <= DMA_RD_A;
                    end
                end
                DMA_RD_A, DMA_RD_B: begin
                    if (can_req) begin
                        mem_req_o <= 1'b1;
                    end else if (xfer_done) begin
                        mem_req_o <= 1'b0;
                        row_q     <= row_q + 1'b1;
                        if (row_q == ROW_W'(MAT_N - 1)) begin
                            if (state_q == DMA_RD_A) begin
                                state_q <= DMA_RD_B;
                            end else begin
                                // operands complete, kick the MAC engine
                                state_q    <= DMA_WAIT_MM;
                                mm_start_o <= 1'b1;
                            end
                        end
                    end
                end
                DMA_WAIT_MM: begin
                    if (mm_done_i) begin
                        state_q <= DMA_WR_C;
                    end
                end
                DMA_WR_C: begin
                    if (can_req) begin
                        mem_req_o <= 1'b1;
                    end else if (xfer_done) begin
                        mem_req_o <= 1'b0;
                        c_cnt_q   <= c_cnt_q + 1'b1;
                        // last result stored
                        if (c_cnt_q == C_IDX_W'(MAT_N*MAT_N - 1)) begin
                            state_q <= DMA_IDLE;
                            done_o  <= 1'b1;
                        end
                    end
                end
                default: state_q <= DMA_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == DMA_IDLE) && start_i) begin
            a_base_q <= mat_a_addr_i;
            b_base_q <= mat_b_addr_i;
            c_base_q <= mat_c_addr_i;
        end
    end

    // request fields, stable while req is high since counters move only on ack
    always_comb begin
        case (state_q)
            DMA_RD_A: mem_addr_o = a_base_q + MEM_AW'(row_q);
            DMA_RD_B: mem_addr_o = b_base_q + MEM_AW'(row_q);
            default:  mem_addr_o = c_base_q + MEM_AW'(c_cnt_q);
        endcase
    end

    assign mem_op_o    = (state_q == DMA_WR_C) ? MEM_WRITE : MEM_READ;
    assign mem_wdata_o = mem_word_t'(c_data_i);
    assign c_idx_o     = c_cnt_q;

    // each read lands in the buffer on its ack
    assign buf_we_o    = rd_state && xfer_done;
    assign buf_sel_b_o = (state_q == DMA_RD_B);
    assign buf_row_o   = row_q;
    assign buf_wdata_o = mem_rdata_i;

endmodule

`default_nettype wire

//--- matmul_engine.sv
// sequential multiply-accumulate engine for C = A x B
// one MAC per cycle, 64 cycles from start_i to done_o
// results kept in a register file read by the DMA engine
`default_nettype none

module matmul_engine (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                start_i,
    output logic [mm_geom_pkg::ROW_W-1:0]      a_row_o,
    output logic [mm_geom_pkg::ROW_W-1:0]      b_row_o,
    input  wire mm_geom_pkg::mem_word_t        a_rdata_i,
    input  wire mm_geom_pkg::mem_word_t        b_rdata_i,
    output logic                               done_o,
    input  wire [mm_geom_pkg::C_IDX_W-1:0]     c_idx_i,
    output mm_geom_pkg::acc_t                  c_data_o
);
    import mm_geom_pkg::*;
    import mm_ctrl_pkg::*;

    mm_state_e state_q;
    // {i, j, k}, k fastest
    logic [C_IDX_W+ROW_W-1:0] step_q;
    logic [ROW_W-1:0]         k_idx;
    logic [C_IDX_W-1:0]       c_wr_idx;
    elem_t                    a_elem;
    elem_t                    b_elem;
    acc_t                     prod;
    acc_t                     acc_sum;
    acc_t                     acc_q;
    acc_t                     c_rf [MAT_N*MAT_N];

    assign k_idx    = step_q[ROW_W-1:0];
    // i*4 + j
    assign c_wr_idx = step_q[C_IDX_W+ROW_W-1:ROW_W];

    // A row i, B row k
    assign a_row_o = step_q[C_IDX_W+ROW_W-1:C_IDX_W];
    assign b_row_o = k_idx;

    // byte k of A row i times byte j of B row k
    assign a_elem = elem_t'(a_rdata_i[k_idx*ELEM_W +: ELEM_W]);
    assign b_elem = elem_t'(b_rdata_i[step_q[2*ROW_W-1:ROW_W]*ELEM_W +: ELEM_W]);
    assign prod   = a_elem * b_elem;

    // restart the sum at k == 0
    assign acc_sum = ((k_idx == '0) ? '0 : acc_q) + prod;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= MM_IDLE;
            step_q  <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                MM_IDLE: begin
                    if (start_i) begin
                        state_q <= MM_RUN;
                        step_q  <= '0;
                    end
                end
                MM_RUN: begin
                    step_q <= step_q + 1'b1;
                    // 64th step
                    if (&step_q) begin
                        state_q <= MM_IDLE;
                        done_o  <= 1'b1;
                    end
                end
                default: state_q <= MM_IDLE;
            endcase
        end
    end

    // accumulator and result file
    always_ff @(posedge clk) begin
        if (state_q == MM_RUN) begin
            acc_q <= acc_sum;
            if (k_idx == ROW_W'(MAT_N - 1)) begin
                c_rf[c_wr_idx] <= acc_sum;
            end
        end
    end

    assign c_data_o = c_rf[c_idx_i];

endmodule

`default_nettype wire

//--- operand_buffer.sv
// row storage for operands A and B
// DMA engine writes one row per completed read, MAC engine reads both banks
`default_nettype none

module operand_buffer (
    input  wire                                      clk,
    input  wire                                      we_i,
    input  wire                                      sel_b_i,
    input  wire [mm_geom_pkg::ROW_W-1:0]             wrow_i,
    input  wire mm_geom_pkg::mem_word_t              wdata_i,
    input  wire [mm_geom_pkg::ROW_W-1:0]             a_row_i,
    input  wire [mm_geom_pkg::ROW_W-1:0]             b_row_i,
    output mm_geom_pkg::mem_word_t                   a_rdata_o,
    output mm_geom_pkg::mem_word_t                   b_rdata_o
);
    import mm_geom_pkg::*;

    // one word per matrix row
    mem_word_t a_bank_q [MAT_N];
    mem_word_t b_bank_q [MAT_N];

    always_ff @(posedge clk) begin
        if (we_i) begin
            if (sel_b_i) begin
                b_bank_q[wrow_i] <= wdata_i;
            end else begin
                a_bank_q[wrow_i] <= wdata_i;
            end
        end
    end

    // combinational reads for the MAC engine
    assign a_rdata_o = a_bank_q[a_row_i];
    assign b_rdata_o = b_bank_q[b_row_i];

endmodule

`default_nettype wire

//--- mem_arbiter.sv
// round-robin arbiter between host and DMA engine in front of the shared memory
// both sides use four-phase req/ack, grant held until the requester drops req
`default_nettype none

module mem_arbiter (
    input  wire                         clk,
    input  wire                         rst_n,
    // host requester
    input  wire                         host_req_i,
    input  wire mm_ctrl_pkg::mem_op_e   host_op_i,
    input  wire mm_geom_pkg::mem_addr_t host_addr_i,
    input  wire mm_geom_pkg::mem_word_t host_wdata_i,
    output logic                        host_ack_o,
    output mm_geom_pkg::mem_word_t      host_rdata_o,
    // DMA requester
    input  wire                         dma_req_i,
    input  wire mm_ctrl_pkg::mem_op_e   dma_op_i,
    input  wire mm_geom_pkg::mem_addr_t dma_addr_i,
    input  wire mm_geom_pkg::mem_word_t dma_wdata_i,
    output logic                        dma_ack_o,
    output mm_geom_pkg::mem_word_t      dma_rdata_o,
    // memory side
    output logic                        mem_en_o,
    output logic                        mem_we_o,
    output mm_geom_pkg::mem_addr_t      mem_addr_o,
    output mm_geom_pkg::mem_word_t      mem_wdata_o,
    input  wire mm_geom_pkg::mem_word_t mem_rdata_i
);
    import mm_geom_pkg::*;
    import mm_ctrl_pkg::*;

    // one-hot grant, bit 0 host, bit 1 DMA
    logic [1:0] gnt_q;
    logic       last_dma_q;
    // memory access cycle of the current grant
    logic       acc_q;
    logic       ack_q;
    logic       pick_dma;
    logic       gnt_req;
    mem_op_e    gnt_op;

    // dma wins if alone, or if host was served last
    assign pick_dma = dma_req_i && (!host_req_i || !last_dma_q);
    assign gnt_req  = gnt_q[1] ? dma_req_i : host_req_i;
    assign gnt_op   = gnt_q[1] ? dma_op_i : host_op_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gnt_q      <= 2'b00;
            last_dma_q <= 1'b0;
            acc_q      <= 1'b0;
            ack_q      <= 1'b0;
        end else if (gnt_q == 2'b00) begin
            // arbitrate only with no grant held
            if (host_req_i || dma_req_i) begin
                gnt_q      <= pick_dma ? 2'b10 : 2'b01;
                last_dma_q <= pick_dma;
                acc_q      <= 1'b1;
            end
        end else if (acc_q) begin
            // access done at this edge
            acc_q <= 1'b0;
            ack_q <= 1'b1;
        end else if (!gnt_req) begin
            // req seen low, close the handshake and free the grant
            ack_q <= 1'b0;
            gnt_q <= 2'b00;
        end
    end

    // granted requester drives the memory for one cycle
    assign mem_en_o    = acc_q;
    assign mem_we_o    = acc_q && (gnt_op == MEM_WRITE);
    assign mem_addr_o  = gnt_q[1] ? dma_addr_i : host_addr_i;
    assign mem_wdata_o = gnt_q[1] ? dma_wdata_i : host_wdata_i;

    assign host_ack_o = ack_q && gnt_q[0];
    assign dma_ack_o  = ack_q && gnt_q[1];
    // memory output register keeps the read word while ack is high
    assign host_rdata_o = mem_rdata_i;
    assign dma_rdata_o  = mem_rdata_i;

endmodule

`default_nettype wire

//--- shared_mem.sv
// single-port word memory shared by host and DMA engine
// one access per cycle, read data registered and held until the next access
`default_nettype none

module shared_mem (
    input  wire                     clk,
    input  wire                     en_i,
    input  wire                     we_i,
    input  wire mm_geom_pkg::mem_addr_t addr_i,
    input  wire mm_geom_pkg::mem_word_t wdata_i,
    output mm_geom_pkg::mem_word_t  rdata_o
);
    import mm_geom_pkg::*;

    // 256 words, no reset
    mem_word_t mem_q [2**MEM_AW];

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem_q[addr_i] <= wdata_i;
            end else begin
                // read port only moves on a read
                rdata_o <= mem_q[addr_i];
            end
        end
    end

endmodule

`default_nettype wire

//--- mm_ctrl_pkg.sv
// control encodings for the accelerator
// memory opcode of the req/ack ports and the FSM states of DMA and MAC engines
`default_nettype none

package mm_ctrl_pkg;

    // opcode carried with every memory request
    typedef enum logic {
        MEM_READ,
        MEM_WRITE
    } mem_op_e;

    // DMA engine sequence
    typedef enum logic [2:0] {
        DMA_IDLE,
        DMA_RD_A,       // four row reads of A
        DMA_RD_B,       // four row reads of B
        DMA_WAIT_MM,    // MAC engine running
        DMA_WR_C        // sixteen result writes
    } dma_state_e;

    // MAC engine
    typedef enum logic {
        MM_IDLE,
        MM_RUN
    } mm_state_e;

endpackage

`default_nettype wire

//--- mm_geom_pkg.sv
// sizes and word types shared by the matrix-multiply accelerator
// memory words hold one matrix row, element j in byte j
`default_nettype none

package mm_geom_pkg;

    // matrix and element geometry
    localparam int MAT_N   = 4;
    localparam int ELEM_W  = 8;
    localparam int ACC_W   = 32;
    localparam int ROW_W   = $clog2(MAT_N);
    // index into the 16 results of C
    localparam int C_IDX_W = 4;

    // shared word memory, 256 words
    localparam int MEM_AW  = 8;
    localparam int MEM_DW  = 32;

    typedef logic [MEM_AW-1:0]        mem_addr_t;
    typedef logic [MEM_DW-1:0]        mem_word_t;
    typedef logic signed [ELEM_W-1:0] elem_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

endpackage

`default_nettype wire
